// File: common/i8008_pkg.sv
`default_nettype none

package i8008_pkg;

  localparam int DATA_W      = 8;
  localparam int ADDR_W      = 14;
  localparam int STACK_DEPTH = 8;
  localparam int SP_W        = 3;
  localparam int NUM_REGS    = 7;  // A, B, C, D, E, H, L
  localparam int FLAG_W      = 4;

  // Flag vector layout, same order as the condition code in opcode bits 4..3
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_S = 2;
  localparam int FLAG_P = 3;

  localparam logic [2:0] REG_A   = 3'd0;  // Accumulator
  localparam logic [2:0] REG_MEM = 3'd7;  // M operand on the 8008, not supported here

  // Work requested from the data unit
  typedef enum logic [2:0] {
    DOP_NONE,
    DOP_MOVE,
    DOP_LOAD_IMM,
    DOP_INC,
    DOP_DEC,
    DOP_ALU_REG,
    DOP_ALU_IMM,
    DOP_ROTATE
  } data_op_e;

  // 8008 ALU function field, opcode bits 5..3
  typedef enum logic [2:0] {
    ADD = 3'd0,
    ADC = 3'd1,
    SUB = 3'd2,
    SBB = 3'd3,
    AND = 3'd4,
    XOR = 3'd5,
    OR  = 3'd6,
    CMP = 3'd7
  } alu_op_e;

  // Rotate select, opcode bits 4..3
  typedef enum logic [1:0] {
    RLC = 2'd0,
    RRC = 2'd1,
    RAL = 2'd2,
    RAR = 2'd3
  } rot_op_e;

  typedef enum logic [1:0] {
    FOP_STEP,
    FOP_JUMP,
    FOP_CALL,
    FOP_RET
  } flow_op_e;

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } exec_state_e;

endpackage

`default_nettype wire

// File: data_unit/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic [i8008_pkg::DATA_W-1:0]  a,
  input  logic [i8008_pkg::DATA_W-1:0]  b,
  input  logic                          carry_in,
  input  i8008_pkg::data_op_e           data_op,
  input  i8008_pkg::alu_op_e            alu_op,
  input  i8008_pkg::rot_op_e            rot_op,
  output logic [i8008_pkg::DATA_W-1:0]  result,
  output logic [i8008_pkg::FLAG_W-1:0]  flags_next
);
  import i8008_pkg::*;

  logic [DATA_W:0] sum;  // Extra bit carries out or borrows
  logic            carry_out;

  always_comb begin
    sum       = '0;
    result    = a;
    carry_out = carry_in;  // INC and DEC keep carry
    case (data_op)
      DOP_INC: result = a + 8'd1;
      DOP_DEC: result = a - 8'd1;
      DOP_ROTATE: begin
        case (rot_op)
          RLC:     {carry_out, result} = {a[7], a[6:0], a[7]};
          RRC:     {carry_out, result} = {a[0], a[0], a[7:1]};
          RAL:     {carry_out, result} = {a[7], a[6:0], carry_in};  // Through carry
          default: {carry_out, result} = {a[0], carry_in, a[7:1]};
        endcase
      end
      DOP_ALU_REG, DOP_ALU_IMM: begin
        case (alu_op)
          ADD:      sum = {1'b0, a} + {1'b0, b};
          ADC:      sum = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, carry_in};
          SUB, CMP: sum = {1'b0, a} - {1'b0, b};
          SBB:      sum = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, carry_in};
          AND:      sum = {1'b0, a & b};
          XOR:      sum = {1'b0, a ^ b};
          default:  sum = {1'b0, a | b};
        endcase
        result    = sum[DATA_W-1:0];
        carry_out = sum[DATA_W];  // Logic ops leave bit 8 clear
      end
      default: ;
    endcase
  end

  always_comb begin
    flags_next         = '0;
    flags_next[FLAG_C] = carry_out;
    flags_next[FLAG_Z] = (result == '0);
    flags_next[FLAG_S] = result[DATA_W-1];
    flags_next[FLAG_P] = ~^result;  // Set on even number of ones
  end

endmodule

`default_nettype wire

// File: data_unit/data_unit.sv
`timescale 1ns/1ns
`default_nettype none

module data_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          exec_en,
  input  i8008_pkg::data_op_e           data_op,
  input  i8008_pkg::alu_op_e            alu_op,
  input  i8008_pkg::rot_op_e            rot_op,
  input  logic [2:0]                    dst,
  input  logic [2:0]                    src,
  input  logic [i8008_pkg::DATA_W-1:0]  imm,
  input  logic [2:0]                    reg_sel,
  output logic [i8008_pkg::DATA_W-1:0]  reg_data,
  output logic [i8008_pkg::DATA_W-1:0]  acc,
  output logic [i8008_pkg::FLAG_W-1:0]  flags
);
  import i8008_pkg::*;

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic [FLAG_W-1:0] flags_q;
  logic [FLAG_W-1:0] flags_next;
  logic [DATA_W-1:0] src_val;
  logic [DATA_W-1:0] alu_a;
  logic [DATA_W-1:0] alu_b;
  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] wr_data;
  logic [2:0]        wr_sel;
  logic              reg_we;
  logic              flag_we;

  assign src_val = regs[src];
  assign alu_a   = (data_op == DOP_INC || data_op == DOP_DEC) ? regs[dst] : regs[REG_A];
  assign alu_b   = (data_op == DOP_ALU_IMM) ? imm : src_val;

  alu i_alu (
    .a         (alu_a),
    .b         (alu_b),
    .carry_in  (flags_q[FLAG_C]),
    .data_op   (data_op),
    .alu_op    (alu_op),
    .rot_op    (rot_op),
    .result    (alu_result),
    .flags_next(flags_next)
  );

  // Write-back selection
  always_comb begin
    wr_data = alu_result;
    wr_sel  = REG_A;  // ALU ops and rotates land in A
    reg_we  = 1'b0;
    flag_we = 1'b0;
    case (data_op)
      DOP_MOVE: begin
        wr_data = src_val;
        wr_sel  = dst;
        reg_we  = 1'b1;
      end
      DOP_LOAD_IMM: begin
        wr_data = imm;
        wr_sel  = dst;
        reg_we  = 1'b1;
      end
      DOP_INC, DOP_DEC: begin
        wr_sel  = dst;
        reg_we  = 1'b1;
        flag_we = 1'b1;
      end
      DOP_ALU_REG, DOP_ALU_IMM: begin
        reg_we  = (alu_op != CMP);  // Compare only touches flags
        flag_we = 1'b1;
      end
      DOP_ROTATE: begin
        reg_we  = 1'b1;
        flag_we = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
      flags_q <= '0;
    end else if (exec_en) begin
      if (reg_we)
        regs[wr_sel] <= wr_data;
      if (flag_we && data_op == DOP_ROTATE)
        flags_q[FLAG_C] <= flags_next[FLAG_C];  // Z, S, P kept on rotates
      else if (flag_we)
        flags_q <= flags_next;
    end
  end

  assign reg_data = (reg_sel == REG_MEM) ? '0 : regs[reg_sel];
  assign acc      = regs[REG_A];
  assign flags    = flags_q;

  // Decoder must never let code 111 reach the register file
  no_mem_write_a: assert property (@(posedge clk) disable iff (rst)
    exec_en && reg_we |-> wr_sel != REG_MEM);

endmodule

`default_nettype wire

// File: flow_unit/pc_stack.sv
`timescale 1ns/1ns
`default_nettype none

module pc_stack (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          exec_en,
  input  i8008_pkg::flow_op_e           flow_op,
  input  logic [1:0]                    instr_len,
  input  logic [i8008_pkg::ADDR_W-1:0]  target,
  output logic [i8008_pkg::ADDR_W-1:0]  pc,
  output logic [i8008_pkg::SP_W-1:0]    stack_ptr
);
  import i8008_pkg::*;

  logic [ADDR_W-1:0] stack_mem [STACK_DEPTH];
  logic [SP_W-1:0]   sp_q;
  logic [SP_W-1:0]   sp_inc;
  logic [SP_W-1:0]   sp_dec;
  logic [ADDR_W-1:0] pc_next;
  logic              sp_at_top;
  logic              sp_at_bottom;

  // The active entry is the program counter
  assign pc           = stack_mem[sp_q];
  assign pc_next      = pc + ADDR_W'(instr_len);  // Wraps at 2^14
  assign sp_inc       = sp_q + SP_W'(1);
  assign sp_dec       = sp_q - SP_W'(1);
  assign sp_at_top    = (sp_q == SP_W'(STACK_DEPTH - 1));
  assign sp_at_bottom = (sp_q == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < STACK_DEPTH; i++)
        stack_mem[i] <= '0;
      sp_q <= '0;
    end else if (exec_en) begin
      case (flow_op)
        FOP_JUMP: stack_mem[sp_q] <= target;
        FOP_CALL: begin
          if (sp_at_top) begin
            stack_mem[sp_q] <= target;  // Full stack, return address dropped
          end else begin
            stack_mem[sp_q]   <= pc_next;
            stack_mem[sp_inc] <= target;
            sp_q              <= sp_inc;
          end
        end
        FOP_RET: begin
          if (sp_at_bottom)
            stack_mem[sp_q] <= pc_next;  // Nothing to pop
          else
            sp_q <= sp_dec;
        end
        default: stack_mem[sp_q] <= pc_next;
      endcase
    end
  end

  assign stack_ptr = sp_q;

  // One push or one pop per executed instruction at most
  sp_step_a: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && $changed(sp_q) |->
      $past(exec_en) && ($past(sp_q) + 1 == sp_q || sp_q + 1 == $past(sp_q)));

endmodule

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [i8008_pkg::DATA_W-1:0]  opcode,
  input  logic [i8008_pkg::DATA_W-1:0]  operand_lo,
  input  logic [i8008_pkg::DATA_W-1:0]  operand_hi,
  input  logic [i8008_pkg::FLAG_W-1:0]  flags,
  output logic                          exec_en,
  output i8008_pkg::data_op_e           data_op,
  output i8008_pkg::alu_op_e            alu_op,
  output i8008_pkg::rot_op_e            rot_op,
  output logic [2:0]                    dst,
  output logic [2:0]                    src,
  output logic [i8008_pkg::DATA_W-1:0]  imm,
  output i8008_pkg::flow_op_e           flow_op,
  output logic [1:0]                    instr_len,
  output logic [i8008_pkg::ADDR_W-1:0]  target,
  output logic                          halted
);
  import i8008_pkg::*;

  exec_state_e state;
  logic        flag_bit;
  logic        cond_true;
  logic        is_hlt;

  // Condition field: bits 4..3 pick the flag, bit 5 picks the sense
  always_comb begin
    case (opcode[4:3])
      2'd0:    flag_bit = flags[FLAG_C];
      2'd1:    flag_bit = flags[FLAG_Z];
      2'd2:    flag_bit = flags[FLAG_S];
      default: flag_bit = flags[FLAG_P];
    endcase
  end

  assign cond_true = (flag_bit == opcode[5]);

  always_comb begin
    data_op   = DOP_NONE;
    alu_op    = alu_op_e'(opcode[5:3]);
    rot_op    = rot_op_e'(opcode[4:3]);
    dst       = opcode[5:3];
    src       = opcode[2:0];
    imm       = operand_lo;
    flow_op   = FOP_STEP;
    instr_len = 2'd1;
    target    = {operand_hi[ADDR_W-DATA_W-1:0], operand_lo};
    is_hlt    = 1'b0;

    case (opcode[7:6])
      2'b00: begin
        case (opcode[2:0])
          3'b000, 3'b001: begin
            if (opcode[5:3] == 3'b000)
              is_hlt = 1'b1;
            else if (dst != REG_MEM)
              data_op = opcode[0] ? DOP_DEC : DOP_INC;
          end
          3'b010: if (!opcode[5]) data_op = DOP_ROTATE;  // 00 1xx 010 is unused
          3'b011: if (cond_true) flow_op = FOP_RET;
          3'b100: begin
            data_op   = DOP_ALU_IMM;
            instr_len = 2'd2;
          end
          3'b101: begin  // RST, one-byte call to AAA000
            flow_op = FOP_CALL;
            target  = {{(ADDR_W-6){1'b0}}, opcode[5:3], 3'b000};
          end
          3'b110: begin
            if (dst != REG_MEM) begin  // LMI falls through as one byte
              data_op   = DOP_LOAD_IMM;
              instr_len = 2'd2;
            end
          end
          default: flow_op = FOP_RET;
        endcase
      end
      2'b01: begin
        instr_len = opcode[0] ? 2'd1 : 2'd3;  // Odd codes are INP/OUT
        case (opcode[2:0])
          3'b000:  if (cond_true) flow_op = FOP_JUMP;
          3'b010:  if (cond_true) flow_op = FOP_CALL;
          3'b100:  flow_op = FOP_JUMP;
          3'b110:  flow_op = FOP_CALL;
          default: ;
        endcase
      end
      2'b10: if (src != REG_MEM) data_op = DOP_ALU_REG;
      default: begin
        if (opcode == 8'hff)
          is_hlt = 1'b1;
        else if (dst != REG_MEM && src != REG_MEM)
          data_op = DOP_MOVE;
      end
    endcase
  end

  assign exec_en = instr_valid && (state == ST_RUN);
  assign halted  = (state == ST_HALTED);

  // Only reset leaves the halted state
  always_ff @(posedge clk) begin
    if (rst)
      state <= ST_RUN;
    else if (exec_en && is_hlt)
      state <= ST_HALTED;
  end

  halt_sticky_a: assert property (@(posedge clk) $fell(halted) |-> $past(rst));

endmodule

`default_nettype wire

// File: verilog/i8008_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module i8008_exec_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [i8008_pkg::DATA_W-1:0]  opcode,
  input  logic [i8008_pkg::DATA_W-1:0]  operand_lo,
  input  logic [i8008_pkg::DATA_W-1:0]  operand_hi,
  input  logic [2:0]                    reg_sel,
  output logic [i8008_pkg::DATA_W-1:0]  reg_data,
  output logic [i8008_pkg::DATA_W-1:0]  acc,
  output logic [i8008_pkg::ADDR_W-1:0]  pc,
  output logic [i8008_pkg::FLAG_W-1:0]  flags,
  output logic [i8008_pkg::SP_W-1:0]    stack_ptr,
  output logic                          halted
);
  import i8008_pkg::*;

  logic              exec_en;
  data_op_e          data_op;
  alu_op_e           alu_op;
  rot_op_e           rot_op;
  logic [2:0]        dst;
  logic [2:0]        src;
  logic [DATA_W-1:0] imm;
  flow_op_e          flow_op;
  logic [1:0]        instr_len;
  logic [ADDR_W-1:0] target;

  instr_decode i_instr_decode (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .opcode     (opcode),
    .operand_lo (operand_lo),
    .operand_hi (operand_hi),
    .flags      (flags),
    .exec_en    (exec_en),
    .data_op    (data_op),
    .alu_op     (alu_op),
    .rot_op     (rot_op),
    .dst        (dst),
    .src        (src),
    .imm        (imm),
    .flow_op    (flow_op),
    .instr_len  (instr_len),
    .target     (target),
    .halted     (halted)
  );

  data_unit i_data_unit (
    .clk     (clk),
    .rst     (rst),
    .exec_en (exec_en),
    .data_op (data_op),
    .alu_op  (alu_op),
    .rot_op  (rot_op),
    .dst     (dst),
    .src     (src),
    .imm     (imm),
    .reg_sel (reg_sel),
    .reg_data(reg_data),
    .acc     (acc),
    .flags   (flags)
  );

  pc_stack i_pc_stack (
    .clk      (clk),
    .rst      (rst),
    .exec_en  (exec_en),
    .flow_op  (flow_op),
    .instr_len(instr_len),
    .target   (target),
    .pc       (pc),
    .stack_ptr(stack_ptr)
  );

endmodule

`default_nettype wire

// File: bench/tb_i8008_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i8008_exec;

  localparam int CLK_HALF    = 50;
  localparam int CLK_PERIOD  = 2 * CLK_HALF;
  localparam     GOLDEN_FILE = "bench/i8008_golden.txt";

  logic        clk = 1'b0;
  logic        rst;
  logic        instr_valid;
  logic [7:0]  opcode;
  logic [7:0]  operand_lo;
  logic [7:0]  operand_hi;
  logic [2:0]  reg_sel;
  logic [7:0]  reg_data;
  logic [7:0]  acc;
  logic [13:0] pc;
  logic [3:0]  flags;
  logic [2:0]  stack_ptr;
  logic        halted;

  // One queue per golden column
  logic [15:0] g_opcode[$];
  logic [15:0] g_lo[$];
  logic [15:0] g_hi[$];
  logic [15:0] g_sel[$];
  logic [15:0] g_reg_data[$];
  logic [15:0] g_acc[$];
  logic [15:0] g_pc[$];
  logic [15:0] g_flags[$];
  logic [15:0] g_sp[$];
  logic [15:0] g_halted[$];
  int          num_vectors    = 0;
  logic        vectors_loaded = 1'b0;

  i8008_exec_top i_i8008_exec_top (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .opcode     (opcode),
    .operand_lo (operand_lo),
    .operand_hi (operand_hi),
    .reg_sel    (reg_sel),
    .reg_data   (reg_data),
    .acc        (acc),
    .pc         (pc),
    .flags      (flags),
    .stack_ptr  (stack_ptr),
    .halted     (halted)
  );

  always #CLK_HALF clk = ~clk;

  task automatic check_value(input string name, input logic [15:0] exp_val,
                             input logic [15:0] got);
    assert (got === exp_val) else begin
      $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, got);
      $display("ERRORS FOUND");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  task automatic check_outputs(input int i);
    check_value("reg_data", g_reg_data[i], {8'h00, reg_data});
    check_value("acc", g_acc[i], {8'h00, acc});
    check_value("pc", g_pc[i], {2'b00, pc});
    check_value("flags", g_flags[i], {12'h000, flags});
    check_value("stack_ptr", g_sp[i], {13'h0000, stack_ptr});
    check_value("halted", g_halted[i], {15'h0000, halted});
  endtask

  // Instruction bytes of vector i, sampled as a strobe at the next edge
  task automatic drive_instr(input int i);
    instr_valid <= 1'b1;
    opcode      <= g_opcode[i][7:0];
    operand_lo  <= g_lo[i][7:0];
    operand_hi  <= g_hi[i][7:0];
  endtask

  // Five reset cycles, then every register must read back as zero
  task automatic apply_reset();
    @(posedge clk);
    rst         <= 1'b1;
    instr_valid <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < 8; r++) begin
      reg_sel <= 3'(r);
      @(negedge clk);
      check_value("reg_data", 16'h0, {8'h00, reg_data});
      check_value("acc", 16'h0, {8'h00, acc});
      check_value("pc", 16'h0, {2'b00, pc});
      check_value("flags", 16'h0, {12'h000, flags});
      check_value("stack_ptr", 16'h0, {13'h0000, stack_ptr});
      check_value("halted", 16'h0, {15'h0000, halted});
      @(posedge clk);
    end
  endtask

  task automatic load_golden();
    int               fd;
    int               n;
    int               line_no;
    logic [31:0]      f [10];
    logic [8*160-1:0] line;
    fd      = $fopen(GOLDEN_FILE, "r");
    line_no = 0;
    if (fd == 0) begin
      $display("Cannot open the golden vector file %s", GOLDEN_FILE);
      $display("ERRORS FOUND");
      $fatal(1, "Golden file missing");
    end
    while ($fgets(line, fd) != 0) begin
      line_no++;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
      if (n == 10) begin
        g_opcode.push_back(f[0][15:0]);
        g_lo.push_back(f[1][15:0]);
        g_hi.push_back(f[2][15:0]);
        g_sel.push_back(f[3][15:0]);
        g_reg_data.push_back(f[4][15:0]);
        g_acc.push_back(f[5][15:0]);
        g_pc.push_back(f[6][15:0]);
        g_flags.push_back(f[7][15:0]);
        g_sp.push_back(f[8][15:0]);
        g_halted.push_back(f[9][15:0]);
      end else if (n > 0) begin
        $display("Golden file line %0d has %0d of 10 columns", line_no, n);
        $display("ERRORS FOUND");
        $fatal(1, "Malformed golden file");
      end
    end
    $fclose(fd);
    if (g_opcode.size() == 0) begin
      $display("The golden vector file holds no vectors");
      $display("ERRORS FOUND");
      $fatal(1, "Empty golden file");
    end
  endtask

  initial begin
    int unsigned idle;
    rst         <= 1'b1;
    instr_valid <= 1'b0;
    opcode      <= 8'h00;
    operand_lo  <= 8'h00;
    operand_hi  <= 8'h00;
    reg_sel     <= 3'd0;
    void'($urandom(32'hbd82));
    load_golden();
    num_vectors    = g_opcode.size();
    vectors_loaded = 1'b1;
    apply_reset();
    @(posedge clk);
    drive_instr(0);
    for (int i = 0; i < num_vectors; i++) begin
      @(posedge clk);  // Vector i executes at this edge
      reg_sel <= g_sel[i][2:0];  // Read-back follows the executed vector
      idle = $urandom % 4;
      if (idle == 0 && i + 1 < num_vectors)
        drive_instr(i + 1);  // Back-to-back strobe
      else
        instr_valid <= 1'b0;
      @(negedge clk);
      check_outputs(i);
      if (idle != 0) begin  // Quiet cycles must hold every output
        repeat (idle) @(posedge clk);
        if (i + 1 < num_vectors)
          drive_instr(i + 1);
        @(negedge clk);
        check_outputs(i);
      end
    end
    apply_reset();  // Only reset clears halted
    $display("NO ERRORS");
    $finish;
  end

  // Up to 6 cycles per vector plus both reset sequences
  initial begin
    time limit;
    wait (vectors_loaded);
    limit = time'(num_vectors) * 6 * CLK_PERIOD + 30 * CLK_PERIOD;
    #(limit);
    $display("Timeout: the run did not finish within %0t ns", limit);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: compile.f
common/i8008_pkg.sv
data_unit/alu.sv
data_unit/data_unit.sv
flow_unit/pc_stack.sv
verilog/instr_decode.sv
verilog/i8008_exec_top.sv
bench/tb_i8008_exec.sv

// File: Bender.yml
package:
  name: i8008_exec

sources:
  # Package first, then leaf modules, then the top level
  - common/i8008_pkg.sv
  - data_unit/alu.sv
  - data_unit/data_unit.sv
  - flow_unit/pc_stack.sv
  - verilog/instr_decode.sv
  - verilog/i8008_exec_top.sv
  - target: test
    files:
      - bench/tb_i8008_exec.sv

// File: bench/i8008_golden.txt
# opcode operand_lo operand_hi reg_sel  exp_reg_data exp_acc exp_pc exp_flags exp_sp exp_halted
# all columns hex, flags = {P,S,Z,C}
0e ff 00 1  ff 00 0002 0 0 0
06 3c 00 0  3c 3c 0004 0 0 0
08 00 00 1  00 3c 0005 a 0 0
09 00 00 1  ff 3c 0006 c 0 0
d1 00 00 2  ff 3c 0007 c 0 0
82 00 00 0  3b 3b 0008 1 0 0
0c 04 00 0  40 40 000a 0 0 0
14 41 00 0  ff ff 000c d 0 0
9b 00 00 0  fe fe 000d 4 0 0
24 0f 00 0  0e 0e 000f 0 0 0
a9 00 00 0  f1 f1 0010 4 0 0
34 0e 00 0  ff ff 0012 c 0 0
3c ff 00 0  ff ff 0014 a 0 0
2c ff 00 0  00 00 0016 a 0 0
ba 00 00 0  00 00 0017 1 0 0
89 00 00 0  00 00 0018 b 0 0
b1 00 00 0  ff ff 0019 c 0 0
04 02 00 0  01 01 001b 1 0 0
92 00 00 0  02 02 001c 1 0 0
a1 00 00 0  02 02 001d 0 0 0
1c 01 00 0  01 01 001f 0 0 0
0a 00 00 0  80 80 0020 1 0 0
1a 00 00 0  c0 c0 0021 0 0 0
02 00 00 0  81 81 0022 1 0 0
12 00 00 0  03 03 0023 1 0 0
60 00 01 0  03 03 0100 1 0 0
40 00 02 0  03 03 0103 1 0 0
48 00 42 0  03 03 0200 1 0 0
68 00 03 0  03 03 0203 1 0 0
70 00 03 0  03 03 0206 1 0 0
58 fe ff 0  03 03 3ffe 1 0 0
78 00 00 0  03 03 0001 1 0 0
50 40 00 0  03 03 0040 1 0 0
c7 00 00 7  00 03 0041 1 0 0
3e 55 00 0  03 03 0042 1 0 0
41 00 00 0  03 03 0043 1 0 0
38 00 00 0  03 03 0044 1 0 0
46 00 05 0  03 03 0500 1 1 0
07 00 00 0  03 03 0047 1 0 0
3d 00 00 0  03 03 0038 1 1 0
62 23 01 0  03 03 0123 1 2 0
42 00 00 0  03 03 0126 1 2 0
03 00 00 0  03 03 0127 1 2 0
23 00 00 0  03 03 003b 1 1 0
0f 00 00 0  03 03 0048 1 0 0
07 00 00 0  03 03 0049 1 0 0
0d 00 00 0  03 03 0008 1 1 0
15 00 00 0  03 03 0010 1 2 0
1d 00 00 0  03 03 0018 1 3 0
25 00 00 0  03 03 0020 1 4 0
2d 00 00 0  03 03 0028 1 5 0
35 00 00 0  03 03 0030 1 6 0
3d 00 00 0  03 03 0038 1 7 0
46 77 07 0  03 03 0777 1 7 0
07 00 00 0  03 03 0031 1 6 0
20 00 00 4  01 03 0032 1 6 0
21 00 00 4  00 03 0033 b 6 0
00 00 00 0  03 03 0034 b 6 1
06 77 00 0  03 03 0034 b 6 1
44 00 10 0  03 03 0034 b 6 1
